// ==== compile.f ====
+incdir+logic
logic/memCtrlPkg.sv
logic/memArbiter.sv
logic/byteSequencer.sv
logic/memCtrl.sv
testbench/tbClock.sv
testbench/tbRam.sv
testbench/tbMemCtrl.sv

// ==== testbench/tbMemCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "memCtrl_cfg.svh"

module tbMemCtrl
    import memCtrlPkg::*;
();

    localparam int fetchRuns    = 4;
    localparam int lenRuns      = 6;
    localparam int priorityRuns = 2;
    localparam int freezeRuns   = 12;
    // each store is followed by a readback load
    localparam int numTrans = fetchRuns + 3 * lenRuns + 2 * priorityRuns + 2 * freezeRuns;

    logic                  clk;
    logic                  rst;
    logic                  rdy;
    logic                  ioBufferFull;
    logic                  freeze;
    logic                  fetchEn;
    logic [`MC_ADDR_W-1:0] fetchAddr;
    logic                  dataEn;
    dataReqT               dataReq;
    logic [`MC_BYTE_W-1:0] memRdata;
    memBusT                memBus;
    logic                  fetchDone;
    logic [`MC_WORD_W-1:0] fetchInst;
    logic                  dataDone;
    logic [`MC_WORD_W-1:0] dataRdata;
    ownerT                 owner;
    logic                  ramFrozenWrite;

    logic [7:0]  mirror [0:255];
    int          lens [3] = '{1, 2, 4};
    integer      seed;
    string       testName;
    logic [31:0] expFetchInst;
    logic [31:0] expDataWord;
    logic        expIsLoad;
    int          expDataLat;
    logic        checkLatency;
    logic        priorityTest;
    int          priorityMark;
    int          cycleNo = 0;
    int          ownedCycles = 0;
    int          fetchDoneCount = 0;
    int          dataDoneCount = 0;
    int          failCount = 0;

    assign freeze = ioBufferFull || !rdy;

    tbClock u_clock (
        .clk (clk),
        .rst (rst)
    );

    tbRam u_ram (
        .clk           (clk),
        .i_freeze      (freeze),
        .i_memBus      (memBus),
        .o_rdata       (memRdata),
        .o_frozenWrite (ramFrozenWrite)
    );

    memCtrl u_dut (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (rdy),
        .i_ioBufferFull (ioBufferFull),
        .i_fetchEn      (fetchEn),
        .i_fetchAddr    (fetchAddr),
        .i_dataEn       (dataEn),
        .i_dataReq      (dataReq),
        .i_memRdata     (memRdata),
        .o_memBus       (memBus),
        .o_fetchDone    (fetchDone),
        .o_fetchInst    (fetchInst),
        .o_dataDone     (dataDone),
        .o_dataRdata    (dataRdata),
        .o_owner        (owner)
    );

    // cycle k after acceptance reads ownedCycles == k
    always @(posedge clk) begin
        cycleNo <= cycleNo + 1;
        ownedCycles <= (owner == ownerNone) ? 0 : ownedCycles + 1;
        if (fetchDone)
            fetchDoneCount <= fetchDoneCount + 1;
        if (dataDone)
            dataDoneCount <= dataDoneCount + 1;
    end

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        failCount++;
        $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic reportFailure(input string reason);
        failCount++;
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    // little-endian word from the mirror, zero above len bytes
    function automatic logic [31:0] mirrorWord(input logic [31:0] addr, input int len);
        logic [31:0] word;
        logic [31:0] byteAddr;
        word = '0;
        for (int k = 0; k < len; k++) begin
            byteAddr = addr + k;
            word[8*k +: 8] = mirror[byteAddr[7:0]];
        end
        return word;
    endfunction

    task automatic storeMirror(input logic [31:0] addr, input int len, input logic [31:0] wdata);
        logic [31:0] byteAddr;
        for (int k = 0; k < len; k++) begin
            byteAddr = addr + k;
            mirror[byteAddr[7:0]] = wdata[8*k +: 8];
        end
    endtask

    task automatic driveFreeze(inout int budget, inout int runLeft);
        logic [31:0] r;
        r = $random(seed);
        if (runLeft == 0 && budget > 0 && r[1:0] == 2'd0) begin
            runLeft = (r[3:2] + 1 > budget) ? budget : r[3:2] + 1;
            budget = budget - runLeft;
        end
        if (runLeft > 0) begin
            runLeft = runLeft - 1;
            // r[4] picks a full I/O buffer or a dropped ready
            ioBufferFull = r[4];
            rdy = r[4];
        end else begin
            ioBufferFull = 1'b0;
            rdy = 1'b1;
        end
    endtask

    task automatic waitForDone(input bit fetchSide, input bit withFreeze);
        int startCount;
        int budget;
        int runLeft;
        bit finished;
        startCount = fetchSide ? fetchDoneCount : dataDoneCount;
        budget = withFreeze ? 6 : 0;
        runLeft = 0;
        finished = 1'b0;
        checkLatency = !withFreeze;
        while (!finished) begin
            @(posedge clk);
            #1;
            if ((fetchSide ? fetchDoneCount : dataDoneCount) != startCount)
                finished = 1'b1;
            else
                driveFreeze(budget, runLeft);
        end
        ioBufferFull = 1'b0;
        rdy = 1'b1;
    endtask

    task automatic fetchAccess(input string name, input logic [31:0] addr, input bit withFreeze);
        testName = name;
        expFetchInst = mirrorWord(addr, `MC_FETCH_LEN);
        fetchAddr = addr;
        fetchEn = 1'b1;
        waitForDone(1'b1, withFreeze);
        fetchEn = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic dataAccess(input string name, input bit isStore, input logic [31:0] addr,
                              input int len, input logic [31:0] wdata, input bit withFreeze);
        testName = name;
        expIsLoad = !isStore;
        expDataWord = mirrorWord(addr, len);
        expDataLat = isStore ? len - 1 : len;
        dataReq.isStore = isStore;
        dataReq.len = len[`MC_LEN_W-1:0];
        dataReq.addr = addr;
        dataReq.wdata = wdata;
        dataEn = 1'b1;
        waitForDone(1'b0, withFreeze);
        if (isStore)
            storeMirror(addr, len, wdata);
        dataEn = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic storeAndCheck(input logic [31:0] addr, input int len, input bit withFreeze);
        dataAccess("store", 1'b1, addr, len, $random(seed), withFreeze);
        dataAccess("store readback", 1'b0, addr, 4, $random(seed), withFreeze);
    endtask

    // both clients ask in the same idle cycle
    task automatic priorityPair(input logic [31:0] fetchAt, input logic [31:0] loadAt,
                                input int len);
        int fetchStart;
        fetchStart = fetchDoneCount;
        priorityMark = dataDoneCount;
        priorityTest = 1'b1;
        checkLatency = 1'b1;
        testName = "priority";
        expFetchInst = mirrorWord(fetchAt, `MC_FETCH_LEN);
        expIsLoad = 1'b1;
        expDataWord = mirrorWord(loadAt, len);
        expDataLat = len;
        fetchAddr = fetchAt;
        dataReq.isStore = 1'b0;
        dataReq.len = len[`MC_LEN_W-1:0];
        dataReq.addr = loadAt;
        dataReq.wdata = '0;
        fetchEn = 1'b1;
        dataEn = 1'b1;
        while (fetchDoneCount == fetchStart) begin
            @(posedge clk);
            #1;
            if (dataDoneCount != priorityMark)
                dataEn = 1'b0;
        end
        fetchEn = 1'b0;
        priorityTest = 1'b0;
        @(posedge clk);
        #1;
    endtask

    resetQuiet: assert property (
        @(posedge clk) (cycleNo >= 1 && cycleNo <= 17)
        |-> (!fetchDone && !dataDone && !memBus.rw && owner == ownerNone)
    ) else reportMismatch("reset", 32'd0, {27'd0, $sampled(fetchDone),
                          $sampled(dataDone), $sampled(memBus.rw), $sampled(owner)});

    fetchWord: assert property (
        @(posedge clk) fetchDone |-> (fetchInst == expFetchInst)
    ) else reportMismatch({testName, " inst"}, expFetchInst, $sampled(fetchInst));

    fetchLatency: assert property (
        @(posedge clk) (fetchDone && checkLatency) |-> (ownedCycles == `MC_FETCH_LEN)
    ) else reportMismatch({testName, " fetch cycles"}, `MC_FETCH_LEN, $sampled(ownedCycles));

    loadWord: assert property (
        @(posedge clk) (dataDone && expIsLoad) |-> (dataRdata == expDataWord)
    ) else reportMismatch({testName, " rdata"}, expDataWord, $sampled(dataRdata));

    dataLatency: assert property (
        @(posedge clk) (dataDone && checkLatency) |-> (ownedCycles == expDataLat)
    ) else reportMismatch({testName, " data cycles"}, expDataLat, $sampled(ownedCycles));

    dataWinsTie: assert property (
        @(posedge clk) (priorityTest && owner == ownerNone && fetchEn && dataEn && !freeze)
        |=> (owner == ownerData)
    ) else reportMismatch("priority owner", ownerData, $sampled(owner));

    dataDoneFirst: assert property (
        @(posedge clk) (priorityTest && fetchDone) |-> (dataDoneCount != priorityMark)
    ) else reportFailure("fetch finished before the data access in the priority test");

    noFrozenWrite: assert property (
        @(posedge clk) !ramFrozenWrite
    ) else reportFailure("the RAM was written while the controller was frozen");

    initial begin
        #(numTrans * 16 * 10 + 1000);
        reportFailure("watchdog expired before all transactions completed");
    end

    initial begin
        logic [31:0] pick;
        seed = 32'h6582e123;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataReq = '0;
        testName = "reset";
        expFetchInst = '0;
        expDataWord = '0;
        expIsLoad = 1'b0;
        expDataLat = 0;
        checkLatency = 1'b0;
        priorityTest = 1'b0;
        priorityMark = 0;
        for (int a = 0; a < 256; a++)
            mirror[a] = a[7:0] ^ 8'hA5;
        @(negedge rst);
        repeat (3) @(posedge clk);
        #1;
        for (int i = 0; i < fetchRuns; i++)
            fetchAccess("fetch", $random(seed), 1'b0);
        for (int i = 0; i < lenRuns; i++)
            dataAccess("load", 1'b0, $random(seed), lens[i % 3], $random(seed), 1'b0);
        for (int i = 0; i < lenRuns; i++)
            storeAndCheck($random(seed), lens[i % 3], 1'b0);
        for (int i = 0; i < priorityRuns; i++)
            priorityPair($random(seed), $random(seed), lens[i % 3]);
        // mixed traffic with freeze runs
        for (int i = 0; i < freezeRuns; i++) begin
            pick = $random(seed);
            if (pick[1:0] == 2'd0)
                fetchAccess("fetch frozen", $random(seed), 1'b1);
            else if (pick[1:0] == 2'd1)
                dataAccess("load frozen", 1'b0, $random(seed), lens[pick[3:2] % 3],
                           $random(seed), 1'b1);
            else
                storeAndCheck($random(seed), lens[pick[3:2] % 3], 1'b1);
        end
        repeat (4) @(posedge clk);
        if (failCount == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "errors were recorded");
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tbRam.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "memCtrl_cfg.svh"

module tbRam
    import memCtrlPkg::*;
(
    input  wire                   clk,
    input  wire                   i_freeze,
    input  wire memBusT           i_memBus,
    output logic [`MC_BYTE_W-1:0] o_rdata,
    output logic                  o_frozenWrite
);

    // 256 bytes, upper address bits alias onto them
    logic [`MC_BYTE_W-1:0] mem [0:255];

    initial begin
        for (int a = 0; a < 256; a++)
            mem[a] = a[7:0] ^ 8'hA5;
        o_rdata = '0;
        o_frozenWrite = 1'b0;
    end

    // read data lags the address by one cycle
    always @(posedge clk) begin
        o_rdata <= mem[i_memBus.addr[7:0]];
        if (i_memBus.rw)
            mem[i_memBus.addr[7:0]] <= i_memBus.wdata;
    end

    // a frozen controller must leave the RAM untouched
    noWriteWhileFrozen: assert property (
        @(posedge clk) i_freeze |-> !i_memBus.rw
    ) else o_frozenWrite = 1'b1;

endmodule

`default_nettype wire

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int halfPeriod  = 5,
    parameter int resetCycles = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // released just after an edge, like the rest of the stimulus
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== logic/memCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "memCtrl_cfg.svh"

module memCtrl
    import memCtrlPkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   i_rdy,
    input  wire                   i_ioBufferFull,
    input  wire                   i_fetchEn,
    input  wire [`MC_ADDR_W-1:0]  i_fetchAddr,
    input  wire                   i_dataEn,
    input  wire dataReqT          i_dataReq,
    input  wire [`MC_BYTE_W-1:0]  i_memRdata,
    output memBusT                o_memBus,
    output logic                  o_fetchDone,
    output logic [`MC_WORD_W-1:0] o_fetchInst,
    output logic                  o_dataDone,
    output logic [`MC_WORD_W-1:0] o_dataRdata,
    output ownerT                 o_owner
);

    logic                  freeze;
    logic                  active;
    accessT                access;
    logic                  seqDone;
    logic [`MC_WORD_W-1:0] seqRdata;

    // whole controller stalls on a full I/O buffer or when not ready
    assign freeze = i_ioBufferFull || !i_rdy;

    assign active = (o_owner != ownerNone);

    memArbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .i_freeze     (freeze),
        .i_fetchEn    (i_fetchEn),
        .i_fetchAddr  (i_fetchAddr),
        .i_dataEn     (i_dataEn),
        .i_dataReq    (i_dataReq),
        .i_accessDone (seqDone),
        .o_access     (access),
        .o_owner      (o_owner)
    );

    byteSequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .i_freeze   (freeze),
        .i_active   (active),
        .i_access   (access),
        .i_memRdata (i_memRdata),
        .o_memBus   (o_memBus),
        .o_done     (seqDone),
        .o_rdata    (seqRdata)
    );

    // done and read data only go to the client that owns the bus
    always_comb begin
        o_fetchDone = 1'b0;
        o_fetchInst = '0;
        o_dataDone  = 1'b0;
        o_dataRdata = '0;
        if (o_owner == ownerFetch) begin
            o_fetchDone = seqDone;
            o_fetchInst = seqRdata;
        end else if (o_owner == ownerData) begin
            o_dataDone  = seqDone;
            o_dataRdata = seqRdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/byteSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "memCtrl_cfg.svh"

module byteSequencer
    import memCtrlPkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   i_freeze,
    input  wire                   i_active,
    input  wire accessT           i_access,
    input  wire [`MC_BYTE_W-1:0]  i_memRdata,
    output memBusT                o_memBus,
    output logic                  o_done,
    output logic [`MC_WORD_W-1:0] o_rdata
);

    logic [`MC_LEN_W-1:0]             stage;
    logic [`MC_LEN_W-1:0]             addrOffset;
    logic [`MC_WORD_W-`MC_BYTE_W-1:0] partial;
    logic                             advance;
    logic                             lastStage;

    assign advance = i_active && !i_freeze;

    // writes end on the last issued byte, reads once that byte has come back
    assign lastStage = i_access.isStore ? (stage == i_access.len - 1'b1)
                                        : (stage == i_access.len);

    assign o_done = advance && lastStage;

    // While frozen the previous address is repeated, so the byte that
    // would have been captured in the frozen cycle is returned again.
    always_comb begin
        if (i_freeze && (stage != '0)) begin
            addrOffset = stage - 1'b1;
        end else begin
            addrOffset = stage;
        end
    end

    always_comb begin
        o_memBus.rw   = advance && i_access.isStore;
        o_memBus.addr = i_access.addr
                      + {{(`MC_ADDR_W-`MC_LEN_W){1'b0}}, addrOffset};
        // little-endian with stage 0 carrying the low byte
        case (stage)
            3'd0: begin
                o_memBus.wdata = i_access.wdata[7:0];
            end
            3'd1: begin
                o_memBus.wdata = i_access.wdata[15:8];
            end
            3'd2: begin
                o_memBus.wdata = i_access.wdata[23:16];
            end
            default: begin
                o_memBus.wdata = i_access.wdata[31:24];
            end
        endcase
    end

    // stage counter holds while frozen
    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else if (advance) begin
            if (o_done) begin
                stage <= '0;
            end else begin
                stage <= stage + 1'b1;
            end
        end
    end

    // byte k shows up on the RAM bus while stage is k+1
    always_ff @(posedge clk) begin
        if (advance && !i_access.isStore) begin
            case (stage)
                3'd1: begin
                    partial[7:0] <= i_memRdata;
                end
                3'd2: begin
                    partial[15:8] <= i_memRdata;
                end
                3'd3: begin
                    partial[23:16] <= i_memRdata;
                end
                default: begin
                end
            endcase
        end
    end

    // final byte comes straight from the RAM and upper bytes are zeroed
    always_comb begin
        case (i_access.len)
            3'd1: begin
                o_rdata = {{(`MC_WORD_W-`MC_BYTE_W){1'b0}}, i_memRdata};
            end
            3'd2: begin
                o_rdata = {{(`MC_WORD_W-2*`MC_BYTE_W){1'b0}}, i_memRdata, partial[7:0]};
            end
            default: begin
                o_rdata = {i_memRdata, partial};
            end
        endcase
    end

    // stage may only reach len on a read and never pass it
    stageInRange: assert property (
        @(posedge clk) disable iff (rst)
        i_active |-> (stage <= i_access.len)
    ) else $error("byteSequencer: stage %0d beyond len %0d", stage, i_access.len);

    // a freeze must never let a byte into the RAM
    noWriteWhenFrozen: assert property (
        @(posedge clk) disable iff (rst)
        i_freeze |-> !o_memBus.rw
    ) else $error("byteSequencer: write issued while frozen");

endmodule

`default_nettype wire

// ==== logic/memArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "memCtrl_cfg.svh"

module memArbiter
    import memCtrlPkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  i_freeze,
    input  wire                  i_fetchEn,
    input  wire [`MC_ADDR_W-1:0] i_fetchAddr,
    input  wire                  i_dataEn,
    input  wire dataReqT         i_dataReq,
    input  wire                  i_accessDone,
    output accessT               o_access,
    output ownerT                o_owner
);

    logic   idle;
    logic   accept;
    accessT nextAccess;
    ownerT  nextOwner;

    assign idle = (o_owner == ownerNone);

    // requests are only taken between accesses and outside a freeze
    assign accept = idle && !i_freeze && (i_fetchEn || i_dataEn);

    // data port wins a tie with fetch
    always_comb begin
        if (i_dataEn) begin
            nextOwner          = ownerData;
            nextAccess.isFetch = 1'b0;
            nextAccess.isStore = i_dataReq.isStore;
            nextAccess.len     = i_dataReq.len;
            nextAccess.addr    = i_dataReq.addr;
            nextAccess.wdata   = i_dataReq.wdata;
        end else begin
            nextOwner          = ownerFetch;
            nextAccess.isFetch = 1'b1;
            nextAccess.isStore = 1'b0;
            nextAccess.len     = `MC_FETCH_LEN;
            nextAccess.addr    = i_fetchAddr;
            nextAccess.wdata   = '0;
        end
    end

    // owner drops at the edge closing the done cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            o_owner <= ownerNone;
        end else if (accept) begin
            o_owner <= nextOwner;
        end else if (i_accessDone) begin
            o_owner <= ownerNone;
        end
    end

    // held for the sequencer until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            o_access <= nextAccess;
        end
    end

    // the sequencer only handles 1, 2 and 4 byte transfers
    dataLenLegal: assert property (
        @(posedge clk) disable iff (rst)
        (accept && i_dataEn) |=> (o_access.len inside {3'd1, 3'd2, 3'd4})
    ) else $error("memArbiter: data length %0d accepted", o_access.len);

    // done only comes back from an access that was handed out
    noDoneWhenIdle: assert property (
        @(posedge clk) disable iff (rst)
        i_accessDone |-> !idle
    ) else $error("memArbiter: access done while no owner");

endmodule

`default_nettype wire

// ==== logic/memCtrlPkg.sv ====
`default_nettype none
`include "memCtrl_cfg.svh"

package memCtrlPkg;

    // who holds the RAM bus right now
    typedef enum logic [1:0] {
        ownerNone  = 2'd0,
        ownerFetch = 2'd1,
        ownerData  = 2'd2
    } ownerT;

    // load/store request as the data client presents it
    typedef struct packed {
        logic                  isStore;
        logic [`MC_LEN_W-1:0]  len;
        logic [`MC_ADDR_W-1:0] addr;
        logic [`MC_WORD_W-1:0] wdata;
    } dataReqT;

    // access latched by the arbiter
    typedef struct packed {
        logic                  isFetch;
        logic                  isStore;
        logic [`MC_LEN_W-1:0]  len;
        logic [`MC_ADDR_W-1:0] addr;
        logic [`MC_WORD_W-1:0] wdata;
    } accessT;

    // one RAM cycle, rw high means write
    typedef struct packed {
        logic                  rw;
        logic [`MC_ADDR_W-1:0] addr;
        logic [`MC_BYTE_W-1:0] wdata;
    } memBusT;

endpackage

`default_nettype wire

// ==== logic/memCtrl_cfg.svh ====
`ifndef MEMCTRL_CFG_SVH
`define MEMCTRL_CFG_SVH

// byte-serial memory controller sizes

// processor side address
`define MC_ADDR_W 32

// instruction and load/store word
`define MC_WORD_W 32

// one RAM beat
`define MC_BYTE_W 8

// length field, holds 1, 2 or 4
`define MC_LEN_W 3

// a fetch always moves a whole instruction
// sized to the length field
`define MC_FETCH_LEN 3'd4

`endif
